// ==== sd_pkg.sv ====
package sd_pkg;

    localparam int CMD_FRAME_W = 48;
    localparam int DIV_W = 8;
    // x^7 + x^3 + 1
    localparam logic [6:0] CRC7_POLY = 7'h09;

    typedef enum logic [2:0] {
        REG_ARGUMENT   = 3'd0,
        REG_COMMAND    = 3'd1,
        REG_RESPONSE   = 3'd2,
        REG_INT_STATUS = 3'd3,
        REG_INT_ENABLE = 3'd4,
        REG_CLK_DIV    = 3'd5,
        REG_PRESENT    = 3'd6
    } reg_addr_e;

    typedef struct packed {
        logic        we;
        reg_addr_e   addr;
        logic [31:0] wdata;
    } reg_req_t;

    // Codes 2 and 3 behave as RSP_48
    typedef enum logic [1:0] {
        RSP_NONE = 2'd0,
        RSP_48   = 2'd1
    } rsp_type_e;

    typedef struct packed {
        logic       index_check;
        logic       crc_check;
        rsp_type_e  rsp_type;
        logic [5:0] index;
    } cmd_desc_t;

    typedef struct packed {
        cmd_desc_t   desc;
        logic [31:0] arg;
    } cmd_req_t;

    typedef struct packed {
        logic        timeout;
        logic        crc_ok;
        logic [5:0]  index;
        logic [31:0] status;
    } cmd_raw_t;

    typedef struct packed {
        logic cmd_index_err;
        logic cmd_crc_err;
        logic cmd_timeout;
        logic cmd_complete;
    } int_status_t;

    // One bit of the serial CRC7
    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'd0);
    endfunction

endpackage

// ==== sd_clock_divider.sv ====
`timescale 1ns/1ps

module sd_clock_divider
    import sd_pkg::*;
(
    input  logic             aclk_i,
    input  logic             rst_i,
    input  logic [DIV_W-1:0] divisor_i,
    output logic             sd_clk_o,
    output logic             sd_rise_o,
    output logic             sd_fall_o
);

    logic [DIV_W-1:0] cnt_q;
    logic             toggle;

    // Compare against the live divisor, a smaller value must not overrun
    assign toggle = (cnt_q >= divisor_i);

    // Strobes mark the cycle that ends with the SD clock edge
    assign sd_rise_o = toggle && !sd_clk_o;
    assign sd_fall_o = toggle && sd_clk_o;

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            cnt_q    <= '0;
            sd_clk_o <= 1'b0;
        end else if (toggle) begin
            cnt_q    <= '0;
            sd_clk_o <= ~sd_clk_o;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

// ==== sd_reg_bank.sv ====
`timescale 1ns/1ps

module sd_reg_bank
    import sd_pkg::*;
(
    input  logic             aclk_i,
    input  logic             rst_i,
    input  logic             req_i,
    input  reg_req_t         reg_req_i,
    output logic             ack_o,
    output logic [31:0]      rdata_o,
    output logic [DIV_W-1:0] divisor_o,
    output logic             cmd_start_o,
    output cmd_req_t         cmd_req_o,
    input  logic             cmd_ack_i,
    input  int_status_t      result_i,
    input  logic [31:0]      status_i,
    output logic             interrupt_o
);

    logic [31:0] argument_q;
    cmd_desc_t   command_q;
    logic [31:0] response_q;
    int_status_t int_status_q;
    int_status_t int_enable_q;
    logic        inhibit_q;
    logic        access;
    logic        wr_en;
    logic        result_valid;
    int_status_t w1c_mask;
    int_status_t result_set;
    logic [31:0] rd_data;

    // New access on the first cycle req is seen with ack still low
    assign access       = req_i && !ack_o;
    assign wr_en        = access && reg_req_i.we;
    assign result_valid = cmd_start_o && cmd_ack_i;

    assign w1c_mask = (wr_en && reg_req_i.addr == REG_INT_STATUS) ?
                      int_status_t'(reg_req_i.wdata[3:0]) : int_status_t'(4'd0);
    assign result_set = result_valid ? result_i : int_status_t'(4'd0);

    assign cmd_req_o.desc = command_q;
    assign cmd_req_o.arg  = argument_q;
    assign interrupt_o    = |(int_status_q & int_enable_q);

    always_comb begin
        case (reg_req_i.addr)
            REG_ARGUMENT:   rd_data = argument_q;
            REG_COMMAND:    rd_data = {22'd0, command_q};
            REG_RESPONSE:   rd_data = response_q;
            REG_INT_STATUS: rd_data = {28'd0, int_status_q};
            REG_INT_ENABLE: rd_data = {28'd0, int_enable_q};
            REG_CLK_DIV:    rd_data = {{(32 - DIV_W){1'b0}}, divisor_o};
            REG_PRESENT:    rd_data = {31'd0, inhibit_q};
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            ack_o        <= 1'b0;
            command_q    <= cmd_desc_t'(10'd0);
            response_q   <= '0;
            int_status_q <= int_status_t'(4'd0);
            int_enable_q <= int_status_t'(4'd0);
            divisor_o    <= DIV_W'(1);
            cmd_start_o  <= 1'b0;
            inhibit_q    <= 1'b0;
        end else begin
            // Ack tracks req one cycle later in both directions
            ack_o <= req_i;

            if (wr_en) begin
                case (reg_req_i.addr)
                    REG_COMMAND: begin
                        if (!inhibit_q) begin
                            command_q   <= cmd_desc_t'(reg_req_i.wdata[9:0]);
                            cmd_start_o <= 1'b1;
                            inhibit_q   <= 1'b1;
                        end
                    end
                    REG_INT_ENABLE: int_enable_q <= int_status_t'(reg_req_i.wdata[3:0]);
                    REG_CLK_DIV:    divisor_o <= reg_req_i.wdata[DIV_W-1:0];
                    default: ;
                endcase
            end

            if (result_valid) begin
                response_q  <= status_i;
                cmd_start_o <= 1'b0;
            end else if (inhibit_q && !cmd_start_o && !cmd_ack_i) begin
                inhibit_q <= 1'b0;
            end

            int_status_q <= (int_status_q & ~w1c_mask) | result_set;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (wr_en && reg_req_i.addr == REG_ARGUMENT) begin
            argument_q <= reg_req_i.wdata;
        end
        if (access) begin
            rdata_o <= rd_data;
        end
    end

endmodule

// ==== sd_cmd_master.sv ====
`timescale 1ns/1ps

module sd_cmd_master
    import sd_pkg::*;
(
    input  logic        aclk_i,
    input  logic        rst_i,
    input  logic        cmd_start_i,
    input  cmd_req_t    cmd_req_i,
    output logic        cmd_ack_o,
    output int_status_t result_o,
    output logic [31:0] status_o,
    output logic        xfr_req_o,
    output cmd_req_t    xfr_o,
    input  logic        xfr_ack_i,
    input  cmd_raw_t    raw_i
);

    typedef enum logic [2:0] {
        IDLE,
        XFER,
        WAIT_XFR_DROP,
        DONE,
        WAIT_START_DROP
    } master_state_e;

    master_state_e state_q;
    cmd_req_t      req_q;
    int_status_t   eval_result;
    logic [31:0]   eval_status;
    logic          rsp_valid;

    assign xfr_o = req_q;

    // Error checks only make sense when a response frame arrived
    always_comb begin
        rsp_valid = (req_q.desc.rsp_type != RSP_NONE) && !raw_i.timeout;
        eval_result.cmd_complete  = 1'b1;
        eval_result.cmd_timeout   = raw_i.timeout;
        eval_result.cmd_crc_err   = rsp_valid && req_q.desc.crc_check && !raw_i.crc_ok;
        eval_result.cmd_index_err = rsp_valid && req_q.desc.index_check &&
                                    (raw_i.index != req_q.desc.index);
        eval_status = rsp_valid ? raw_i.status : 32'd0;
    end

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            xfr_req_o <= 1'b0;
            cmd_ack_o <= 1'b0;
            result_o  <= int_status_t'(4'd0);
            status_o  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cmd_start_i) begin
                        xfr_req_o <= 1'b1;
                        state_q   <= XFER;
                    end
                end
                XFER: begin
                    if (xfr_ack_i) begin
                        result_o  <= eval_result;
                        status_o  <= eval_status;
                        xfr_req_o <= 1'b0;
                        state_q   <= WAIT_XFR_DROP;
                    end
                end
                WAIT_XFR_DROP: begin
                    if (!xfr_ack_i) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    cmd_ack_o <= 1'b1;
                    state_q   <= WAIT_START_DROP;
                end
                WAIT_START_DROP: begin
                    if (!cmd_start_i) begin
                        cmd_ack_o <= 1'b0;
                        state_q   <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request held for the whole transfer
    always_ff @(posedge aclk_i) begin
        if (state_q == IDLE && cmd_start_i) begin
            req_q <= cmd_req_i;
        end
    end

endmodule

// ==== sd_cmd_serial_host.sv ====
`timescale 1ns/1ps

module sd_cmd_serial_host
    import sd_pkg::*;
#(
    parameter int RSP_TIMEOUT = 64
) (
    input  logic     aclk_i,
    input  logic     rst_i,
    input  logic     sd_rise_i,
    input  logic     sd_fall_i,
    input  logic     xfr_req_i,
    input  cmd_req_t xfr_i,
    output logic     xfr_ack_o,
    output cmd_raw_t raw_o,
    input  logic     sd_cmd_i,
    output logic     sd_cmd_o,
    output logic     sd_cmd_oe_o
);

    // Start, transmission, index and argument go through the CRC
    localparam int TX_W  = CMD_FRAME_W - 8;
    // Response bits kept after the start bit, end bit dropped
    localparam int RX_W  = CMD_FRAME_W - 2;
    localparam int CNT_W = $clog2(CMD_FRAME_W + 1);
    localparam int TO_W  = $clog2(RSP_TIMEOUT + 1);

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        TURN,
        WAIT_START,
        RECV,
        ACK,
        ACK_DROP
    } cmd_state_e;

    cmd_state_e       state_q;
    logic [TX_W-1:0]  tx_q;
    logic [RX_W-1:0]  rx_q;
    logic [6:0]       crc_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic [TO_W-1:0]  to_cnt_q;

    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            xfr_ack_o   <= 1'b0;
            raw_o       <= '0;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            crc_q       <= '0;
            bit_cnt_q   <= '0;
            to_cnt_q    <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (xfr_req_i) begin
                        bit_cnt_q <= '0;
                        crc_q     <= '0;
                        state_q   <= SEND;
                    end
                end
                SEND: begin
                    if (sd_fall_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q < CNT_W'(TX_W)) begin
                            sd_cmd_oe_o <= 1'b1;
                            sd_cmd_o    <= tx_q[TX_W-1];
                            crc_q       <= crc7_step(crc_q, tx_q[TX_W-1]);
                        end else if (bit_cnt_q < CNT_W'(CMD_FRAME_W - 1)) begin
                            sd_cmd_o <= crc_q[6];
                            crc_q    <= {crc_q[5:0], 1'b0};
                        end else if (bit_cnt_q == CNT_W'(CMD_FRAME_W - 1)) begin
                            sd_cmd_o <= 1'b1;
                        end else begin
                            // End bit has been on the line for a full clock
                            sd_cmd_oe_o <= 1'b0;
                            bit_cnt_q   <= '0;
                            if (xfr_i.desc.rsp_type == RSP_NONE) begin
                                raw_o   <= '0;
                                state_q <= ACK;
                            end else begin
                                state_q <= TURN;
                            end
                        end
                    end
                end
                TURN: begin
                    if (sd_fall_i) begin
                        if (bit_cnt_q == CNT_W'(1)) begin
                            to_cnt_q <= '0;
                            state_q  <= WAIT_START;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                WAIT_START: begin
                    if (sd_rise_i) begin
                        if (!sd_cmd_i) begin
                            bit_cnt_q <= CNT_W'(1);
                            crc_q     <= '0;
                            state_q   <= RECV;
                        end else if (to_cnt_q == TO_W'(RSP_TIMEOUT - 1)) begin
                            raw_o   <= '{timeout: 1'b1, crc_ok: 1'b0, index: '0, status: '0};
                            state_q <= ACK;
                        end else begin
                            to_cnt_q <= to_cnt_q + 1'b1;
                        end
                    end
                end
                RECV: begin
                    if (sd_rise_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q < CNT_W'(CMD_FRAME_W - 1)) begin
                            crc_q <= crc7_step(crc_q, sd_cmd_i);
                        end else begin
                            // CRC run over its own check bits leaves zero
                            raw_o   <= '{timeout: 1'b0,
                                         crc_ok:  (crc_q == 7'd0),
                                         index:   rx_q[RX_W-2 -: 6],
                                         status:  rx_q[RX_W-8 -: 32]};
                            state_q <= ACK;
                        end
                    end
                end
                ACK: begin
                    xfr_ack_o <= 1'b1;
                    state_q   <= ACK_DROP;
                end
                ACK_DROP: begin
                    if (!xfr_req_i) begin
                        xfr_ack_o <= 1'b0;
                        state_q   <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Frame shifters, MSB first
    always_ff @(posedge aclk_i) begin
        if (state_q == IDLE && xfr_req_i) begin
            tx_q <= {1'b0, 1'b1, xfr_i.desc.index, xfr_i.arg};
        end else if (state_q == SEND && sd_fall_i && bit_cnt_q < CNT_W'(TX_W)) begin
            tx_q <= {tx_q[TX_W-2:0], 1'b0};
        end
        if (state_q == RECV && sd_rise_i && bit_cnt_q < CNT_W'(CMD_FRAME_W - 1)) begin
            rx_q <= {rx_q[RX_W-2:0], sd_cmd_i};
        end
    end

endmodule

// ==== sd_emmc_controller.sv ====
`timescale 1ns/1ps

module sd_emmc_controller
    import sd_pkg::*;
#(
    parameter int RSP_TIMEOUT = 64
) (
    input  logic        aclk_i,
    input  logic        rst_i,
    input  logic        req_i,
    input  reg_req_t    reg_req_i,
    output logic        ack_o,
    output logic [31:0] rdata_o,
    output logic        sd_clk_o,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o,
    input  logic        sd_cmd_i,
    output logic        interrupt_o
);

    logic [DIV_W-1:0] divisor;
    logic             sd_rise;
    logic             sd_fall;
    logic             cmd_start;
    logic             cmd_ack;
    cmd_req_t         cmd_req;
    int_status_t      cmd_result;
    logic [31:0]      cmd_status;
    logic             xfr_req;
    logic             xfr_ack;
    cmd_req_t         xfr;
    cmd_raw_t         raw;

    sd_reg_bank reg_bank0 (
        .aclk_i      (aclk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .reg_req_i   (reg_req_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .divisor_o   (divisor),
        .cmd_start_o (cmd_start),
        .cmd_req_o   (cmd_req),
        .cmd_ack_i   (cmd_ack),
        .result_i    (cmd_result),
        .status_i    (cmd_status),
        .interrupt_o (interrupt_o)
    );

    sd_clock_divider clock_divider0 (
        .aclk_i    (aclk_i),
        .rst_i     (rst_i),
        .divisor_i (divisor),
        .sd_clk_o  (sd_clk_o),
        .sd_rise_o (sd_rise),
        .sd_fall_o (sd_fall)
    );

    sd_cmd_master cmd_master0 (
        .aclk_i      (aclk_i),
        .rst_i       (rst_i),
        .cmd_start_i (cmd_start),
        .cmd_req_i   (cmd_req),
        .cmd_ack_o   (cmd_ack),
        .result_o    (cmd_result),
        .status_o    (cmd_status),
        .xfr_req_o   (xfr_req),
        .xfr_o       (xfr),
        .xfr_ack_i   (xfr_ack),
        .raw_i       (raw)
    );

    sd_cmd_serial_host #(
        .RSP_TIMEOUT (RSP_TIMEOUT)
    ) cmd_serial_host0 (
        .aclk_i      (aclk_i),
        .rst_i       (rst_i),
        .sd_rise_i   (sd_rise),
        .sd_fall_i   (sd_fall),
        .xfr_req_i   (xfr_req),
        .xfr_i       (xfr),
        .xfr_ack_o   (xfr_ack),
        .raw_o       (raw),
        .sd_cmd_i    (sd_cmd_i),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

endmodule

// ==== tb_sd_card_model.sv ====
`timescale 1ns/1ps

module tb_sd_card_model (
    input  logic        sd_clk_i,
    input  logic        sd_cmd_i,
    input  logic        sd_cmd_oe_i,
    input  logic [1:0]  mode_i,
    output logic        sd_cmd_o,
    output int          frame_cnt_o,
    output logic [5:0]  rx_index_o,
    output logic [31:0] rx_arg_o,
    output logic        rx_crc_ok_o
);

    localparam logic [1:0] MODE_CRC_FLIP  = 2'd1;
    localparam logic [1:0] MODE_INDEX_INC = 2'd2;
    localparam logic [1:0] MODE_NO_RSP    = 2'd3;

    logic [47:0] frame;
    logic [47:0] rsp;
    logic [5:0]  idx;

    // Serial CRC7 with generator x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_calc(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb  = crc[6] ^ data[i];
            crc = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
        return crc;
    endfunction

    initial begin
        sd_cmd_o    = 1'b1;
        frame_cnt_o = 0;
        rx_index_o  = 6'd0;
        rx_arg_o    = 32'd0;
        rx_crc_ok_o = 1'b0;
        forever begin
            @(posedge sd_clk_i);
            if (sd_cmd_oe_i) begin
                frame[47] = sd_cmd_i;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk_i);
                    frame[i] = sd_cmd_i;
                end
                rx_index_o  = frame[45:40];
                rx_arg_o    = frame[39:8];
                rx_crc_ok_o = !frame[47] && frame[46] && frame[0] &&
                              (crc7_calc(frame[47:8]) == frame[7:1]);
                frame_cnt_o++;
                if (mode_i != MODE_NO_RSP) begin
                    idx = frame[45:40];
                    if (mode_i == MODE_INDEX_INC) begin
                        idx = idx + 6'd1;
                    end
                    rsp[47:8] = {2'b00, idx, frame[39:8] ^ 32'h0000_0900};
                    rsp[7:1]  = crc7_calc(rsp[47:8]);
                    if (mode_i == MODE_CRC_FLIP) begin
                        rsp[1] = ~rsp[1];
                    end
                    rsp[0] = 1'b1;
                    // Two SD clocks of turnaround, bits change on the falling edge
                    repeat (2) @(negedge sd_clk_i);
                    for (int i = 47; i >= 0; i--) begin
                        @(negedge sd_clk_i);
                        sd_cmd_o = rsp[i];
                    end
                    @(negedge sd_clk_i);
                    sd_cmd_o = 1'b1;
                end
            end
        end
    end

endmodule

// ==== tb_sd_emmc_controller.sv ====
`timescale 1ns/1ps

module tb_sd_emmc_controller
    import sd_pkg::*;
();

    localparam time CLK_PERIOD = 20;
    // Nine commands of up to about 500 cycles each plus register traffic
    localparam int MAX_CYCLES = 20000;
    localparam logic [1:0] MODE_NORMAL    = 2'd0;
    localparam logic [1:0] MODE_CRC_FLIP  = 2'd1;
    localparam logic [1:0] MODE_INDEX_INC = 2'd2;
    localparam logic [1:0] MODE_NO_RSP    = 2'd3;
    localparam logic [31:0] STATUS_XOR = 32'h0000_0900;
    // Bit 0 complete, 1 timeout, 2 CRC error, 3 index error
    localparam int_status_t ST_DONE      = int_status_t'(4'b0001);
    localparam int_status_t ST_TIMEOUT   = int_status_t'(4'b0011);
    localparam int_status_t ST_CRC_ERR   = int_status_t'(4'b0101);
    localparam int_status_t ST_INDEX_ERR = int_status_t'(4'b1001);

    logic        aclk = 1'b0;
    logic        rst;
    logic        req;
    reg_req_t    reg_req;
    logic        ack;
    logic [31:0] rdata;
    logic        sd_clk;
    logic        sd_cmd;
    logic        sd_cmd_oe;
    logic        sd_cmd_card;
    logic        irq;
    logic [1:0]  card_mode;
    int          card_frames;
    logic [5:0]  card_index;
    logic [31:0] card_arg;
    logic        card_crc_ok;
    int          errors;
    int          cycle_cnt = 0;

    sd_emmc_controller #(
        .RSP_TIMEOUT (64)
    ) DUT (
        .aclk_i      (aclk),
        .rst_i       (rst),
        .req_i       (req),
        .reg_req_i   (reg_req),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (sd_cmd_card),
        .interrupt_o (irq)
    );

    tb_sd_card_model card0 (
        .sd_clk_i    (sd_clk),
        .sd_cmd_i    (sd_cmd),
        .sd_cmd_oe_i (sd_cmd_oe),
        .mode_i      (card_mode),
        .sd_cmd_o    (sd_cmd_card),
        .frame_cnt_o (card_frames),
        .rx_index_o  (card_index),
        .rx_arg_o    (card_arg),
        .rx_crc_ok_o (card_crc_ok)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_status(input int_status_t got, input int_status_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Four-phase access where ack follows req by one cycle each way
    task automatic bus_access(input logic we, input reg_addr_e addr, input logic [31:0] wdata,
                              output logic [31:0] data);
        @(posedge aclk);
        #2;
        reg_req.we    = we;
        reg_req.addr  = addr;
        reg_req.wdata = wdata;
        req           = 1'b1;
        @(posedge aclk);
        #2;
        check_bit(ack, 1'b1, "ack_o one cycle after req_i rise");
        while (!ack) begin
            @(posedge aclk);
            #2;
        end
        data = rdata;
        req  = 1'b0;
        @(posedge aclk);
        #2;
        check_bit(ack, 1'b0, "ack_o one cycle after req_i fall");
        while (ack) begin
            @(posedge aclk);
            #2;
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_access(1'b1, addr, data, ignored);
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'd0, data);
    endtask

    function automatic cmd_desc_t make_desc(input logic [5:0] index, input rsp_type_e rsp,
                                            input logic crc_chk, input logic idx_chk);
        cmd_desc_t d;
        d.index       = index;
        d.rsp_type    = rsp;
        d.crc_check   = crc_chk;
        d.index_check = idx_chk;
        return d;
    endfunction

    task automatic wait_idle();
        logic [31:0] present;
        present = 32'd1;
        while (present[0]) begin
            reg_read(REG_PRESENT, present);
        end
    endtask

    task automatic run_command(input cmd_desc_t desc, input logic [31:0] arg);
        reg_write(REG_ARGUMENT, arg);
        reg_write(REG_COMMAND, {22'd0, desc});
        wait_idle();
    endtask

    task automatic check_outcome(input int_status_t exp_int, input logic [31:0] exp_rsp,
                                 input string what);
        logic [31:0] word;
        reg_read(REG_INT_STATUS, word);
        check_status(int_status_t'(word[3:0]), exp_int, {what, " INT_STATUS"});
        reg_read(REG_RESPONSE, word);
        check_word(word, exp_rsp, {what, " RESPONSE"});
        reg_write(REG_INT_STATUS, 32'hf);
    endtask

    task automatic test_register_access();
        logic [31:0] word;
        logic [31:0] arg;
        // Idle bus and pin levels out of reset
        check_bit(ack, 1'b0, "ack_o after reset");
        check_bit(irq, 1'b0, "interrupt_o after reset");
        check_bit(sd_cmd_oe, 1'b0, "sd_cmd_oe_o after reset");
        check_bit(sd_cmd, 1'b1, "sd_cmd_o after reset");
        reg_read(REG_CLK_DIV, word);
        check_word(word, 32'd1, "CLK_DIV reset value");
        arg = $urandom;
        reg_write(REG_ARGUMENT, arg);
        reg_read(REG_ARGUMENT, word);
        check_word(word, arg, "ARGUMENT readback");
        reg_write(REG_INT_ENABLE, 32'h5);
        reg_read(REG_INT_ENABLE, word);
        check_word(word, 32'h5, "INT_ENABLE readback");
        reg_write(REG_INT_ENABLE, 32'h0);
        reg_write(REG_CLK_DIV, 32'h2a);
        reg_read(REG_CLK_DIV, word);
        check_word(word, 32'h2a, "CLK_DIV readback");
        reg_write(REG_CLK_DIV, 32'h1);
        reg_read(REG_PRESENT, word);
        check_word(word, 32'd0, "PRESENT when idle");
    endtask

    task automatic test_normal_command();
        logic [31:0] arg;
        arg       = $urandom;
        card_mode = MODE_NORMAL;
        run_command(make_desc(6'd17, RSP_48, 1'b1, 1'b1), arg);
        check_bit(card_crc_ok, 1'b1, "frame format and CRC7 at card");
        check_word({26'd0, card_index}, 32'd17, "command index at card");
        check_word(card_arg, arg, "command argument at card");
        check_outcome(ST_DONE, arg ^ STATUS_XOR, "normal command");
    endtask

    task automatic test_error_detection();
        logic [31:0] arg;
        arg       = $urandom;
        card_mode = MODE_CRC_FLIP;
        run_command(make_desc(6'd8, RSP_48, 1'b1, 1'b1), arg);
        check_outcome(ST_CRC_ERR, arg ^ STATUS_XOR, "flipped CRC");
        arg       = $urandom;
        card_mode = MODE_INDEX_INC;
        run_command(make_desc(6'd8, RSP_48, 1'b1, 1'b1), arg);
        check_outcome(ST_INDEX_ERR, arg ^ STATUS_XOR, "wrong index");
        arg = $urandom;
        run_command(make_desc(6'd8, RSP_48, 1'b1, 1'b0), arg);
        check_outcome(ST_DONE, arg ^ STATUS_XOR, "wrong index unchecked");
    endtask

    task automatic test_no_response();
        logic [31:0] arg;
        card_mode = MODE_NO_RSP;
        run_command(make_desc(6'd13, RSP_48, 1'b1, 1'b1), $urandom);
        check_outcome(ST_TIMEOUT, 32'd0, "no response");
        // Nonzero RESPONSE that the RSP_NONE command has to clear
        arg       = $urandom;
        card_mode = MODE_NORMAL;
        run_command(make_desc(6'd2, RSP_48, 1'b1, 1'b1), arg);
        check_outcome(ST_DONE, arg ^ STATUS_XOR, "response before RSP_NONE");
        card_mode = MODE_NO_RSP;
        run_command(make_desc(6'd0, RSP_NONE, 1'b0, 1'b0), $urandom);
        check_outcome(ST_DONE, 32'd0, "RSP_NONE command");
    endtask

    task automatic test_interrupts_inhibit();
        logic [31:0] word;
        logic [31:0] arg;
        int          frames;
        card_mode = MODE_NORMAL;
        reg_write(REG_INT_ENABLE, 32'h2);
        run_command(make_desc(6'd3, RSP_48, 1'b1, 1'b1), $urandom);
        check_bit(irq, 1'b0, "interrupt_o with complete masked");
        reg_write(REG_INT_ENABLE, 32'h1);
        check_bit(irq, 1'b1, "interrupt_o with complete enabled");
        reg_write(REG_INT_STATUS, 32'hf);
        check_bit(irq, 1'b0, "interrupt_o after clearing INT_STATUS");
        // Second COMMAND write lands while the first is still running
        frames = card_frames;
        arg    = $urandom;
        reg_write(REG_ARGUMENT, arg);
        reg_write(REG_COMMAND, {22'd0, make_desc(6'd9, RSP_48, 1'b1, 1'b1)});
        reg_read(REG_PRESENT, word);
        check_word(word, 32'd1, "PRESENT during command");
        reg_write(REG_COMMAND, {22'd0, make_desc(6'd10, RSP_48, 1'b1, 1'b1)});
        reg_read(REG_COMMAND, word);
        check_word(word, {22'd0, make_desc(6'd9, RSP_48, 1'b1, 1'b1)},
                   "COMMAND after inhibited write");
        wait_idle();
        check_word(32'(card_frames - frames), 32'd1, "frames for two COMMAND writes");
        check_word({26'd0, card_index}, 32'd9, "index of the accepted command");
        check_outcome(ST_DONE, arg ^ STATUS_XOR, "inhibited second write");
    endtask

    task automatic test_clock_period();
        time t_first;
        time t_second;
        reg_write(REG_CLK_DIV, 32'd3);
        @(posedge sd_clk);
        @(posedge sd_clk);
        t_first = $time;
        @(posedge sd_clk);
        t_second = $time;
        check_word(32'((t_second - t_first) / CLK_PERIOD), 32'd8, "sd_clk_o period in cycles");
        reg_write(REG_CLK_DIV, 32'd1);
    endtask

    initial begin
        void'($urandom(32'h1daae0f9));
        rst       = 1'b1;
        req       = 1'b0;
        reg_req   = '0;
        card_mode = MODE_NORMAL;
        errors    = 0;
        repeat (2) @(posedge aclk);
        #2;
        rst = 1'b0;
        test_register_access();
        test_normal_command();
        test_error_detection();
        test_no_response();
        test_interrupts_inhibit();
        test_clock_period();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
sd_pkg.sv
sd_clock_divider.sv
sd_reg_bank.sv
sd_cmd_master.sv
sd_cmd_serial_host.sv
sd_emmc_controller.sv
tb_sd_card_model.sv
tb_sd_emmc_controller.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sd_emmc_controller \
    -f build.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
